// File: include/bridge_defines.svh
/* Bus widths and the source address base shared by the write bridge
   DW must not exceed 128 so that the byte strobe fits in srcaddr
   The low DW/8 bits of HOSTADDR are replaced by the write strobe */

`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// ##################################################
// UMI side
// ##################################################

// Command word width
`define BRIDGE_CW 32

// Data width in bits, at most 128
`define BRIDGE_DW 128

// ##################################################
// Shared address and AXI ID
// ##################################################

`define BRIDGE_AW 64

`define BRIDGE_IDW 8

// Base for the UMI source address, low strobe bits overwritten
`define BRIDGE_HOSTADDR 64'h0000_0000_0000_0000

`endif

// File: verilog/umi_pkg.sv
/* UMI opcode, command word and transaction bundles
   Command fields follow the 32-bit basic UMI layout, error code in user */

`default_nettype none

`include "bridge_defines.svh"

package umi_pkg;

  // Opcodes seen by the bridge
  // RESP_READ never answers a write, used to flag a bad response
  typedef enum logic [4:0] {
    UMI_RESP_READ  = 5'h02,
    UMI_REQ_WRITE  = 5'h03,
    UMI_RESP_WRITE = 5'h04
  } umi_opcode_e;

  // Command word, MSB first, opcode sits in bits 4:0
  typedef struct packed {
    logic [4:0]  hostid;
    logic        ex;
    // Error code on responses
    logic [1:0]  user;
    logic        eof;
    logic        eom;
    logic [1:0]  prot;
    logic [3:0]  qos;
    // Byte count minus one
    logic [7:0]  len;
    logic [2:0]  size;
    umi_opcode_e opcode;
  } umi_cmd_t;

  // Request from host to device
  typedef struct packed {
    logic [`BRIDGE_DW-1:0] data;
    logic [`BRIDGE_AW-1:0] srcaddr;
    logic [`BRIDGE_AW-1:0] dstaddr;
    umi_cmd_t              cmd;
  } umi_req_t;

  // Response from device back to host
  typedef struct packed {
    logic [`BRIDGE_DW-1:0] data;
    logic [`BRIDGE_AW-1:0] srcaddr;
    logic [`BRIDGE_AW-1:0] dstaddr;
    umi_cmd_t              cmd;
  } umi_resp_t;

endpackage

`default_nettype wire

// File: verilog/axi_pkg.sv
/* AXI4 write channel types, address, data and response only
   No lock, cache, AWPROT[2] or WID; WLAST is not carried */

`default_nettype none

`include "bridge_defines.svh"

package axi_pkg;

  // Burst encodings, WRAP is treated as FIXED by the bridge
  typedef enum logic [1:0] {
    AXI_BURST_FIXED = 2'b00,
    AXI_BURST_INCR  = 2'b01,
    AXI_BURST_WRAP  = 2'b10
  } axi_burst_e;

  // BRESP codes
  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
  } axi_resp_e;

  // Write address channel
  typedef struct packed {
    logic [`BRIDGE_IDW-1:0] id;
    logic [`BRIDGE_AW-1:0]  addr;
    logic [7:0]             len;
    logic [2:0]             size;
    axi_burst_e             burst;
    // Only AWPROT[1:0], maps straight to UMI prot
    logic [1:0]             prot;
    logic [3:0]             qos;
  } axi_aw_t;

  // Write data channel, one strobe bit per byte
  typedef struct packed {
    logic [`BRIDGE_DW-1:0]   data;
    logic [`BRIDGE_DW/8-1:0] strb;
  } axi_w_t;

  // Write response channel
  typedef struct packed {
    logic [`BRIDGE_IDW-1:0] id;
    axi_resp_e              resp;
  } axi_b_t;

endpackage

`default_nettype wire

// File: verilog/axi_wr_burst_track.sv
/* Holds the AW fields of the active burst and walks the beat address
   Counts beats down from len+1, WRAP advances like FIXED */

`default_nettype none

`timescale 1ns/1ps

`include "bridge_defines.svh"

module axi_wr_burst_track (
  input  logic                   clk,
  input  logic                   nreset,
  input  axi_pkg::axi_aw_t       aw,
  input  logic                   aw_fire,
  input  logic                   w_fire,
  output logic [`BRIDGE_AW-1:0]  beat_addr,
  output logic [`BRIDGE_IDW-1:0] held_id,
  output logic [1:0]             held_prot,
  output logic [3:0]             held_qos,
  output logic                   no_beats_left
);

  localparam int AW = `BRIDGE_AW;

  // Up to 256 beats, needs nine bits
  logic [8:0]          beats_left;
  logic [2:0]          held_size;
  axi_pkg::axi_burst_e held_burst;
  logic [AW-1:0]       beat_bytes;

  // Beat counter
  // Zero while idle so no_beats_left stays high outside a burst
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      beats_left <= 9'd0;
    end else if (aw_fire) begin
      beats_left <= {1'b0, aw.len} + 9'd1;
    end else if (w_fire) begin
      beats_left <= beats_left - 9'd1;
    end
  end

  assign no_beats_left = (beats_left == 9'd0);

  // Burst attributes, loaded once per transaction
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      held_id    <= aw.id;
      held_prot  <= aw.prot;
      held_qos   <= aw.qos;
      held_size  <= aw.size;
      held_burst <= aw.burst;
    end
  end

  // Bytes per beat from AWSIZE
  assign beat_bytes = {{(AW-1){1'b0}}, 1'b1} << held_size;

  // Beat address, steps only for INCR
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      beat_addr <= aw.addr;
    end else if (w_fire && (held_burst == axi_pkg::AXI_BURST_INCR)) begin
      beat_addr <= beat_addr + beat_bytes;
    end
  end

endmodule

`default_nettype wire

// File: verilog/umi_req_build.sv
/* Turns one AXI write beat into a UMI REQ_WRITE, purely combinational
   Strobe must be contiguous; gaps are not detected and give wrong data */

`default_nettype none

`timescale 1ns/1ps

`include "bridge_defines.svh"

module umi_req_build (
  input  logic [`BRIDGE_AW-1:0] beat_addr,
  input  logic [1:0]            prot,
  input  logic [3:0]            qos,
  input  axi_pkg::axi_w_t       w,
  output umi_pkg::umi_req_t     req,
  output logic                  empty_beat
);

  localparam int DW    = `BRIDGE_DW;
  localparam int AW    = `BRIDGE_AW;
  localparam int STRBW = DW / 8;
  localparam int IW    = $clog2(STRBW);
  // One extra bit so a full strobe count fits
  localparam int CNTW  = IW + 1;
  localparam logic [AW-1:0] HOSTADDR = `BRIDGE_HOSTADDR;

  logic [CNTW-1:0] strb_count;
  logic [CNTW-1:0] low_index;
  logic [7:0]      cmd_len;

  // ##################################################
  // Strobe measurement
  // ##################################################

  // Population count of the strobe
  always_comb begin
    strb_count = '0;
    for (int i = 0; i < STRBW; i++) begin
      strb_count = strb_count + CNTW'(w.strb[i]);
    end
  end

  // Lowest active byte lane
  // Scan down so the last hit is the lowest set bit
  always_comb begin
    low_index = '0;
    for (int i = STRBW - 1; i >= 0; i--) begin
      if (w.strb[i]) begin
        low_index = CNTW'(i);
      end
    end
  end

  assign empty_beat = (w.strb == '0);

  // UMI len is bytes minus one, meaningless for empty beats
  assign cmd_len = 8'(strb_count) - 8'd1;

  // ##################################################
  // Request assembly
  // ##################################################

  always_comb begin
    req = '0;

    // Size stays zero, byte count lives in len alone
    req.cmd.opcode = umi_pkg::UMI_REQ_WRITE;
    req.cmd.size   = 3'd0;
    req.cmd.len    = cmd_len;
    req.cmd.prot   = prot;
    req.cmd.qos    = qos;
    // Any beat may be the last data beat since empty beats can follow
    req.cmd.eom    = 1'b1;

    // Address moves up to the first written byte
    req.dstaddr = beat_addr + AW'(low_index);

    // Raw strobe rides in the low source address bits
    req.srcaddr = {HOSTADDR[AW-1:STRBW], w.strb};

    // Data shifted so the first written byte lands at bit 0
    req.data = w.data >> {low_index, 3'b000};
  end

endmodule

`default_nettype wire

// File: verilog/axiwr2umi.sv
/* AXI4 write to UMI write bridge, one transaction and one beat in flight
   Each beat waits for its UMI response; errors fold into BRESP, last wins
   umi_req_valid and w_ready are combinational from the W and UMI ready inputs */

`default_nettype none

`timescale 1ns/1ps

`include "bridge_defines.svh"

module axiwr2umi (
  input  logic                clk,
  input  logic                nreset,
  // AXI write address
  input  axi_pkg::axi_aw_t    aw,
  input  logic                aw_valid,
  output logic                aw_ready,
  // AXI write data
  input  axi_pkg::axi_w_t     w,
  input  logic                w_valid,
  output logic                w_ready,
  // AXI write response
  output axi_pkg::axi_b_t     b,
  output logic                b_valid,
  input  logic                b_ready,
  // UMI request out
  output umi_pkg::umi_req_t   umi_req,
  output logic                umi_req_valid,
  input  logic                umi_req_ready,
  // UMI response in
  input  umi_pkg::umi_resp_t  umi_resp,
  input  logic                umi_resp_valid,
  output logic                umi_resp_ready
);

  // Elaboration checks on the shared widths
  if (`BRIDGE_DW > 128) begin : g_dw_check
    $error("Data width above 128 bits, strobe no longer fits srcaddr");
  end
  if ($bits(umi_pkg::umi_cmd_t) != `BRIDGE_CW) begin : g_cw_check
    $error("UMI command struct does not match the command width");
  end

  typedef enum logic [1:0] {
    IDLE,
    UMI_WRITE,
    WAIT_UMI_RESP,
    SEND_B_RESP
  } state_e;

  state_e state;
  state_e next_state;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic req_fire;
  logic resp_fire;

  logic [`BRIDGE_AW-1:0]  beat_addr;
  logic [`BRIDGE_IDW-1:0] held_id;
  logic [1:0]             held_prot;
  logic [3:0]             held_qos;
  logic                   no_beats_left;
  logic                   empty_beat;
  logic                   beat_slot;

  axi_pkg::axi_resp_e err_latch;

  assign aw_fire   = aw_valid & aw_ready;
  assign w_fire    = w_valid & w_ready;
  assign b_fire    = b_valid & b_ready;
  assign req_fire  = umi_req_valid & umi_req_ready;
  assign resp_fire = umi_resp_valid & umi_resp_ready;

  // ##################################################
  // Burst tracking and request build
  // ##################################################

  axi_wr_burst_track i_burst_track (
    .clk           (clk),
    .nreset        (nreset),
    .aw            (aw),
    .aw_fire       (aw_fire),
    .w_fire        (w_fire),
    .beat_addr     (beat_addr),
    .held_id       (held_id),
    .held_prot     (held_prot),
    .held_qos      (held_qos),
    .no_beats_left (no_beats_left)
  );

  umi_req_build i_req_build (
    .beat_addr  (beat_addr),
    .prot       (held_prot),
    .qos        (held_qos),
    .w          (w),
    .req        (umi_req),
    .empty_beat (empty_beat)
  );

  // ##################################################
  // Channel handshakes
  // ##################################################

  // A beat may move only in UMI_WRITE with beats still owed
  assign beat_slot = (state == UMI_WRITE) & ~no_beats_left;

  // Empty beats never reach UMI
  assign umi_req_valid  = beat_slot & w_valid & ~empty_beat;
  // W taken only together with its request, or alone when empty
  assign w_ready        = beat_slot & (umi_req_ready | empty_beat);
  assign umi_resp_ready = (state == WAIT_UMI_RESP);
  assign aw_ready       = (state == IDLE);
  assign b_valid        = (state == SEND_B_RESP);

  assign b.id   = held_id;
  assign b.resp = err_latch;

  // ##################################################
  // Error latch
  // ##################################################

  // Cleared per transaction
  // Wrong opcode beats any device error code
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      err_latch <= axi_pkg::AXI_RESP_OKAY;
    end else if (aw_fire) begin
      err_latch <= axi_pkg::AXI_RESP_OKAY;
    end else if (resp_fire) begin
      if (umi_resp.cmd.opcode != umi_pkg::UMI_RESP_WRITE) begin
        err_latch <= axi_pkg::AXI_RESP_SLVERR;
      end else if (umi_resp.cmd.user != 2'b00) begin
        err_latch <= axi_pkg::axi_resp_e'(umi_resp.cmd.user);
      end
    end
  end

  // ##################################################
  // Transaction FSM
  // ##################################################

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (aw_fire) begin
          next_state = UMI_WRITE;
        end
      end
      UMI_WRITE: begin
        // Empty beats stay here, only real requests wait for a response
        if (no_beats_left) begin
          next_state = SEND_B_RESP;
        end else if (req_fire) begin
          next_state = WAIT_UMI_RESP;
        end
      end
      WAIT_UMI_RESP: begin
        if (resp_fire) begin
          next_state = UMI_WRITE;
        end
      end
      SEND_B_RESP: begin
        if (b_fire) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

endmodule

`default_nettype wire

// File: verilog/axi_umi_wr_top.sv
/* Integration top of the AXI4 write to UMI bridge
   Write channels only, no read path; the UMI device sits outside */

`default_nettype none

`timescale 1ns/1ps

module axi_umi_wr_top (
  input  logic                clk,
  input  logic                nreset,
  input  axi_pkg::axi_aw_t    aw,
  input  logic                aw_valid,
  output logic                aw_ready,
  input  axi_pkg::axi_w_t     w,
  input  logic                w_valid,
  output logic                w_ready,
  output axi_pkg::axi_b_t     b,
  output logic                b_valid,
  input  logic                b_ready,
  output umi_pkg::umi_req_t   umi_req,
  output logic                umi_req_valid,
  input  logic                umi_req_ready,
  input  umi_pkg::umi_resp_t  umi_resp,
  input  logic                umi_resp_valid,
  output logic                umi_resp_ready
);

  // Bridge core, all channel structs pass straight through
  axiwr2umi i_axiwr2umi (
    .clk            (clk),
    .nreset         (nreset),
    .aw             (aw),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w              (w),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .b              (b),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .umi_req        (umi_req),
    .umi_req_valid  (umi_req_valid),
    .umi_req_ready  (umi_req_ready),
    .umi_resp       (umi_resp),
    .umi_resp_valid (umi_resp_valid),
    .umi_resp_ready (umi_resp_ready)
  );

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
/* Testbench clock and reset source
   Clock period 100 ns, reset low for the first two cycles */

`default_nettype none

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic nreset
);

  localparam int PERIOD = 100;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released on a falling edge, two full cycles in
  initial begin
    nreset = 1'b0;
    #(2 * PERIOD);
    nreset = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/bridge_assertions.sv
/* Protocol assertions for the bridge core, bound onto axiwr2umi
   Sampled on the rising clock edge, idle while reset is low
   Keeps its own count of owed beats and outstanding responses */

`default_nettype none

`timescale 1ns/1ps

module bridge_assertions (
  input logic               clk,
  input logic               nreset,
  input axi_pkg::axi_aw_t   aw,
  input logic               aw_valid,
  input logic               aw_ready,
  input logic               w_valid,
  input logic               w_ready,
  input logic               umi_req_valid,
  input logic               umi_req_ready,
  input umi_pkg::umi_req_t  umi_req,
  input logic               umi_resp_valid,
  input logic               umi_resp_ready,
  input logic               b_valid,
  input logic               b_ready
);

  // Beats still owed by the current burst
  logic [8:0] beats_owed;
  // A request went out and its response is still missing
  logic       resp_owed;

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      beats_owed <= 9'd0;
    end else if (aw_valid && aw_ready) begin
      beats_owed <= {1'b0, aw.len} + 9'd1;
    end else if (w_valid && w_ready && (beats_owed != 9'd0)) begin
      beats_owed <= beats_owed - 9'd1;
    end
  end

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      resp_owed <= 1'b0;
    end else if (umi_req_valid && umi_req_ready) begin
      resp_owed <= 1'b1;
    end else if (umi_resp_valid && umi_resp_ready) begin
      resp_owed <= 1'b0;
    end
  end

  // W accepted only with a beat owed and no response outstanding
  a_w_ready_slot: assert property (@(posedge clk) disable iff (!nreset)
    w_ready |-> ((beats_owed != 9'd0) && !resp_owed))
    else $error("w_ready high outside beat forwarding");

  // Requests only for a presented beat inside the same window
  a_req_valid_slot: assert property (@(posedge clk) disable iff (!nreset)
    umi_req_valid |-> (w_valid && (beats_owed != 9'd0) && !resp_owed))
    else $error("umi_req_valid high outside beat forwarding");

  // Stalled request keeps valid and payload
  a_req_stable: assert property (@(posedge clk) disable iff (!nreset)
    (umi_req_valid && !umi_req_ready) |=> (umi_req_valid && $stable(umi_req)))
    else $error("UMI request changed while stalled");

  // B held until taken
  a_b_hold: assert property (@(posedge clk) disable iff (!nreset)
    (b_valid && !b_ready) |=> b_valid)
    else $error("b_valid dropped before b_ready");

endmodule

bind axiwr2umi bridge_assertions i_bridge_assertions (
  .clk            (clk),
  .nreset         (nreset),
  .aw             (aw),
  .aw_valid       (aw_valid),
  .aw_ready       (aw_ready),
  .w_valid        (w_valid),
  .w_ready        (w_ready),
  .umi_req_valid  (umi_req_valid),
  .umi_req_ready  (umi_req_ready),
  .umi_req        (umi_req),
  .umi_resp_valid (umi_resp_valid),
  .umi_resp_ready (umi_resp_ready),
  .b_valid        (b_valid),
  .b_ready        (b_ready)
);

`default_nettype wire

// File: tests/tb_axi_umi_wr.sv
/* Testbench for the AXI4 write to UMI bridge, plays AXI master and UMI device
   Inputs change on the falling edge, handshakes are sampled before the rising one
   Response codes 0..3 go out in user, code 4 stands for a wrong opcode */

`default_nettype none

`timescale 1ns/1ps

`include "bridge_defines.svh"

module tb_axi_umi_wr;

  localparam int STRBW = `BRIDGE_DW / 8;
  // Watchdog budget
  localparam int N_TXN           = 40;
  localparam int MAX_BEATS       = 16;
  localparam int MAX_BEAT_CYCLES = 48;
  localparam int WATCHDOG_NS     = N_TXN * MAX_BEATS * MAX_BEAT_CYCLES * 100 * 2;

  logic clk;
  logic nreset;

  axi_pkg::axi_aw_t   aw;
  logic               aw_valid;
  logic               aw_ready;
  axi_pkg::axi_w_t    w;
  logic               w_valid;
  logic               w_ready;
  axi_pkg::axi_b_t    b;
  logic               b_valid;
  logic               b_ready;
  umi_pkg::umi_req_t  umi_req;
  logic               umi_req_valid;
  logic               umi_req_ready;
  umi_pkg::umi_resp_t umi_resp;
  logic               umi_resp_valid;
  logic               umi_resp_ready;

  // Expected traffic, filled by the stimulus
  umi_pkg::umi_req_t exp_q[$];
  axi_pkg::axi_b_t   b_q[$];
  int                code_q[$];
  // Codes the next transaction hands out, OKAY once empty
  int                code_plan[$];

  int resp_pending    = 0;
  int mismatch_count  = 0;
  int fail_count      = 0;
  int ready_pct       = 100;
  int b_pct           = 100;
  int resp_max_delay  = 2;
  int w_gap_max       = 0;

  tb_clkgen i_clkgen (
    .clk    (clk),
    .nreset (nreset)
  );

  axi_umi_wr_top i_axi_umi_wr_top (
    .clk            (clk),
    .nreset         (nreset),
    .aw             (aw),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w              (w),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .b              (b),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .umi_req        (umi_req),
    .umi_req_valid  (umi_req_valid),
    .umi_req_ready  (umi_req_ready),
    .umi_resp       (umi_resp),
    .umi_resp_valid (umi_resp_valid),
    .umi_resp_ready (umi_resp_ready)
  );

  // ##################################################
  // Reference model
  // ##################################################

  // Expected UMI request for one beat, returns 0 for an empty strobe
  function automatic bit expected_req(input axi_pkg::axi_aw_t a, input axi_pkg::axi_w_t wb,
                                      input int beat, output umi_pkg::umi_req_t r);
    int          first;
    int          count;
    logic [63:0] step;
    r = '0;
    first = -1;
    count = 0;
    for (int i = 0; i < STRBW; i++) begin
      if (wb.strb[i]) begin
        count++;
        if (first < 0) begin
          first = i;
        end
      end
    end
    if (count == 0) begin
      return 1'b0;
    end
    // Only INCR walks the address
    if (a.burst == axi_pkg::AXI_BURST_INCR) begin
      step = 64'(beat) << a.size;
    end else begin
      step = 64'd0;
    end
    r.cmd.opcode = umi_pkg::UMI_REQ_WRITE;
    r.cmd.len    = 8'(count - 1);
    r.cmd.prot   = a.prot;
    r.cmd.qos    = a.qos;
    r.cmd.eom    = 1'b1;
    r.dstaddr    = a.addr + step + 64'(first);
    r.srcaddr    = `BRIDGE_HOSTADDR;
    r.srcaddr[STRBW-1:0] = wb.strb;
    r.data       = wb.data >> (8 * first);
    return 1'b1;
  endfunction

  // Strobe patterns: 0 full, 1 random contiguous, 2 contiguous or empty
  function automatic logic [STRBW-1:0] make_strb(input int mode);
    int               lo;
    int               n;
    logic [STRBW-1:0] s;
    if (mode == 0) begin
      return '1;
    end
    if (mode == 2 && $urandom_range(99, 0) < 30) begin
      return '0;
    end
    lo = $urandom_range(STRBW - 1, 0);
    n  = $urandom_range(STRBW - lo, 1);
    for (int i = 0; i < STRBW; i++) begin
      s[i] = (i >= lo) && (i < lo + n);
    end
    return s;
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    mismatch_count++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  // ##################################################
  // AXI master
  // ##################################################

  task automatic run_txn(input logic [7:0] id, input logic [63:0] addr, input logic [7:0] len,
                         input logic [2:0] size, input axi_pkg::axi_burst_e burst,
                         input int strb_mode);
    axi_pkg::axi_aw_t  a;
    axi_pkg::axi_w_t   wb;
    umi_pkg::umi_req_t r;
    axi_pkg::axi_b_t   eb;
    int                code;
    a = '0;
    a.id    = id;
    a.addr  = addr;
    a.len   = len;
    a.size  = size;
    a.burst = burst;
    a.prot  = 2'($urandom);
    a.qos   = 4'($urandom);
    eb.id   = id;
    eb.resp = axi_pkg::AXI_RESP_OKAY;

    @(negedge clk);
    aw = a;
    aw_valid = 1'b1;
    #1;
    while (!aw_ready) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;

    for (int beat = 0; beat <= int'(len); beat++) begin
      wb.data = {$urandom, $urandom, $urandom, $urandom};
      wb.strb = make_strb(strb_mode);
      if (expected_req(a, wb, beat, r)) begin
        exp_q.push_back(r);
        code = (code_plan.size() > 0) ? code_plan.pop_front() : 0;
        code_q.push_back(code);
        // Wrong opcode forces SLVERR, any other error code overwrites
        if (code == 4) begin
          eb.resp = axi_pkg::AXI_RESP_SLVERR;
        end else if (code != 0) begin
          eb.resp = axi_pkg::axi_resp_e'(code);
        end
      end
      repeat ($urandom_range(w_gap_max, 0)) @(negedge clk);
      w = wb;
      w_valid = 1'b1;
      #1;
      while (!w_ready) begin
        @(negedge clk);
        #1;
      end
      @(posedge clk);
      @(negedge clk);
      w_valid = 1'b0;
    end
    b_q.push_back(eb);
  endtask

  // ##################################################
  // UMI device model
  // ##################################################

  // Random ready on the request and B channels
  initial begin
    umi_req_ready = 1'b0;
    b_ready       = 1'b0;
    forever begin
      @(negedge clk);
      umi_req_ready = ($urandom_range(99, 0) < ready_pct);
      b_ready       = ($urandom_range(99, 0) < b_pct);
    end
  end

  // One response per accepted request, after a random delay
  initial begin
    int code;
    umi_resp       = '0;
    umi_resp_valid = 1'b0;
    forever begin
      @(negedge clk);
      if (resp_pending > 0) begin
        resp_pending--;
        repeat ($urandom_range(resp_max_delay, 0)) @(negedge clk);
        code = (code_q.size() > 0) ? code_q.pop_front() : 0;
        umi_resp = '0;
        if (code == 4) begin
          umi_resp.cmd.opcode = umi_pkg::UMI_RESP_READ;
        end else begin
          umi_resp.cmd.opcode = umi_pkg::UMI_RESP_WRITE;
          umi_resp.cmd.user   = 2'(code);
        end
        umi_resp_valid = 1'b1;
        #1;
        while (!umi_resp_ready) begin
          @(negedge clk);
          #1;
        end
        @(posedge clk);
        @(negedge clk);
        umi_resp_valid = 1'b0;
      end
    end
  end

  // ##################################################
  // Checkers
  // ##################################################

  // Request checker, sampled once inputs have settled
  always begin
    umi_pkg::umi_req_t e;
    @(negedge clk);
    #2;
    if (nreset && umi_req_valid && umi_req_ready) begin
      if (exp_q.size() == 0) begin
        fail_count++;
        $display("Request at %0t with no beat expecting one", $time);
      end else begin
        e = exp_q.pop_front();
        if (umi_req.cmd !== e.cmd) begin
          report_mismatch("umi_req.cmd", 128'(umi_req.cmd), 128'(e.cmd));
        end
        if (umi_req.dstaddr !== e.dstaddr) begin
          report_mismatch("umi_req.dstaddr", 128'(umi_req.dstaddr), 128'(e.dstaddr));
        end
        if (umi_req.srcaddr !== e.srcaddr) begin
          report_mismatch("umi_req.srcaddr", 128'(umi_req.srcaddr), 128'(e.srcaddr));
        end
        if (umi_req.data !== e.data) begin
          report_mismatch("umi_req.data", umi_req.data, e.data);
        end
      end
      resp_pending++;
    end
  end

  // Write response checker
  always begin
    axi_pkg::axi_b_t eb;
    @(negedge clk);
    #2;
    if (nreset && b_valid && b_ready) begin
      if (b_q.size() == 0) begin
        fail_count++;
        $display("Write response at %0t with no transaction expecting one", $time);
      end else begin
        eb = b_q.pop_front();
        if (b.id !== eb.id) begin
          report_mismatch("b.id", 128'(b.id), 128'(eb.id));
        end
        if (b.resp !== eb.resp) begin
          report_mismatch("b.resp", 128'(b.resp), 128'(eb.resp));
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("Some tests failed");
    $finish;
  end

  // ##################################################
  // Test sequence
  // ##################################################

  initial begin
    int          len;
    int          size;
    logic [63:0] addr;
    void'($urandom(45630));
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    @(posedge nreset);

    // Single full beat
    run_txn(8'h11, 64'h0000_1000_0000_0040, 8'd0, 3'd4, axi_pkg::AXI_BURST_INCR, 0);

    // Random INCR bursts
    for (int t = 0; t < 10; t++) begin
      size = $urandom_range(4, 0);
      len  = $urandom_range(15, 0);
      addr = {$urandom, $urandom} & ~((64'd1 << size) - 64'd1);
      run_txn(8'(t), addr, 8'(len), 3'(size), axi_pkg::AXI_BURST_INCR, 1);
    end

    // FIXED and WRAP keep the base
    for (int t = 0; t < 6; t++) begin
      addr = {$urandom, $urandom} & ~64'hf;
      run_txn(8'(8'h20 + t), addr, 8'($urandom_range(7, 1)), 3'd4,
              (t % 2 == 0) ? axi_pkg::AXI_BURST_FIXED : axi_pkg::AXI_BURST_WRAP, 1);
    end

    // Partial strobes mixed with empty beats
    for (int t = 0; t < 6; t++) begin
      addr = {$urandom, $urandom} & ~64'hf;
      run_txn(8'(8'h30 + t), addr, 8'($urandom_range(9, 2)), 3'd4,
              axi_pkg::AXI_BURST_INCR, 2);
    end

    // Error folding, last error wins, next one clean
    code_plan.push_back(3);
    run_txn(8'h40, 64'h100, 8'd0, 3'd4, axi_pkg::AXI_BURST_INCR, 0);
    code_plan.push_back(4);
    run_txn(8'h41, 64'h200, 8'd0, 3'd4, axi_pkg::AXI_BURST_INCR, 0);
    code_plan.push_back(3);
    code_plan.push_back(0);
    code_plan.push_back(2);
    code_plan.push_back(0);
    run_txn(8'h42, 64'h300, 8'd3, 3'd4, axi_pkg::AXI_BURST_INCR, 0);
    run_txn(8'h43, 64'h400, 8'd1, 3'd4, axi_pkg::AXI_BURST_INCR, 0);

    // Back-pressure everywhere
    ready_pct      = 40;
    b_pct          = 30;
    resp_max_delay = 8;
    w_gap_max      = 2;
    for (int t = 0; t < 12; t++) begin
      if (t % 3 == 0) begin
        code_plan.push_back($urandom_range(4, 0));
      end
      addr = {$urandom, $urandom} & ~64'hf;
      run_txn(8'(8'h50 + t), addr, 8'($urandom_range(7, 0)), 3'd4,
              axi_pkg::AXI_BURST_INCR, 2);
    end

    // Drain outstanding responses
    while (b_q.size() > 0) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);
    if (exp_q.size() != 0) begin
      fail_count++;
      $display("%0d expected requests never appeared", exp_q.size());
    end
    if (code_q.size() != 0) begin
      fail_count++;
      $display("%0d UMI responses were never requested", code_q.size());
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
verilog/umi_pkg.sv
verilog/axi_pkg.sv
verilog/axi_wr_burst_track.sv
verilog/umi_req_build.sv
verilog/axiwr2umi.sv
verilog/axi_umi_wr_top.sv
tests/tb_clkgen.sv
tests/bridge_assertions.sv
tests/tb_axi_umi_wr.sv

// File: run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_axi_umi_wr \
  -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi

if ! grep -q "All tests passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
